//--- Makefile
SIM  := obj_dir/Vspi_reg_bridge_tb
SRCS := $(wildcard verilog/*.sv test/*.sv)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "sim passed" sim.log

$(SIM): spi_reg_bridge.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module spi_reg_bridge_tb \
		-f spi_reg_bridge.f -o Vspi_reg_bridge_tb

clean:
	rm -rf obj_dir sim.log

//--- spi_reg_bridge.f
verilog/spi_bridge_pkg.sv
verilog/spi_target.sv
verilog/addr_counter.sv
verilog/reg_bank.sv
verilog/xfer_fsm.sv
verilog/spi_reg_bridge.sv
test/spi_reg_bridge_tb.sv

//--- test/spi_reg_bridge_tb.sv
// SPI register bridge testbench
`default_nettype none

module spi_reg_bridge_tb;

    localparam string STIM_FILE = "test/spi_stimulus.txt";
    localparam int    SCK_HALF  = 4;              // clocks per SCK phase
    localparam int    BYTE_CLKS = 16 * SCK_HALF;  // 8 bits, low and high phase each
    localparam int    GAP_MIN   = 8;              // shortest CS high time
    localparam int    GAP_LIMIT = 24;             // one past the longest gap

    logic        clk;
    logic        reset;
    logic        spi_sck;
    logic        spi_copi;
    logic        spi_cs;
    logic        spi_cipo;

    int          tokens[$];      // every hex field of the stimulus file
    int          txn_count;
    int          byte_count;
    int          timeout_limit;  // 0 until the file is sized
    int          cycles;
    int          errors;
    int          checked;
    bit          stimulus_ok;
    logic [15:0] lfsr;           // gap generator state

    spi_reg_bridge u_dut (
        .clk(clk), .reset_i(reset), .spi_sck_i(spi_sck), .spi_copi_i(spi_copi),
        .spi_cs_i(spi_cs), .spi_cipo_o(spi_cipo)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                   // period 40
    end

    function automatic int hex_digit(input byte c);
        if (c >= "0" && c <= "9") return c - "0";
        if (c >= "a" && c <= "f") return c - "a" + 10;
        if (c >= "A" && c <= "F") return c - "A" + 10;
        return -1;                                // separator
    endfunction

    // fields of one line, anything after # dropped
    task automatic split_line(input string line);
        int  val;
        int  d;
        int  i;
        bit  in_tok;
        byte c;
        val    = 0;
        in_tok = 0;
        for (i = 0; i < line.len(); i++) begin
            c = line.getc(i);
            if (c == "#") break;
            d = hex_digit(c);
            if (d >= 0) begin
                val    = val * 16 + d;
                in_tok = 1;
            end else if (in_tok) begin
                tokens.push_back(val);
                val    = 0;
                in_tok = 0;
            end
        end
        if (in_tok) tokens.push_back(val);    // field at end of line
    endtask

    task automatic load_stimulus();
        int    fd;
        int    pos;
        string line;
        stimulus_ok = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s.", STIM_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) split_line(line);
        $fclose(fd);
        stimulus_ok = 1;
        pos = 0;
        while (pos < tokens.size()) begin         // walk records, count bytes
            if (tokens[pos] == 0 || pos + 1 + 2 * tokens[pos] > tokens.size()) begin
                $display("The stimulus file has a broken record at field %0d.", pos);
                stimulus_ok = 0;
                break;
            end
            txn_count++;
            byte_count += tokens[pos];
            pos += 1 + 2 * tokens[pos];
        end
        if (txn_count == 0) begin
            $display("The stimulus file holds no transactions.");
            stimulus_ok = 0;
        end
        timeout_limit = byte_count * BYTE_CLKS + GAP_LIMIT * txn_count + 200;
    endtask

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_gap(output int gap);
        int g;
        g = 0;
        repeat (4) begin                          // one step per bit taken
            lfsr = lfsr_step(lfsr);
            g    = g * 2 + int'(lfsr[0]);
        end
        gap = GAP_MIN + g;                        // 8 to 23 clocks
    endtask

    // one mode 0 byte, msb first, entered and left on a falling clk edge
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        int b;
        for (b = 7; b >= 0; b--) begin
            spi_sck  = 1'b0;
            spi_copi = tx[b];                     // set while SCK low
            repeat (SCK_HALF - 1) @(negedge clk);
            rx[b] = spi_cipo;                     // clock before the rise
            @(negedge clk);
            spi_sck = 1'b1;
            repeat (SCK_HALF) @(negedge clk);
        end
    endtask

    task automatic run_transaction(input int txn, input int pos);
        int         n;
        int         k;
        int         gap;
        logic [7:0] tx_byte;
        logic [7:0] rx;
        logic [7:0] expected;
        n      = tokens[pos];
        spi_cs = 1'b0;                            // SCK already low
        for (k = 0; k < n; k++) begin
            tx_byte  = tokens[pos + 1 + k][7:0];
            expected = tokens[pos + 1 + n + k][7:0];
            shift_byte(tx_byte, rx);
            checked++;
            if (rx !== expected) begin
                errors++;
                $display("ERROR txn %0d byte %0d spi_cipo_o expected 0x%02h got 0x%02h",
                         txn, k, expected, rx);
            end
        end
        spi_sck = 1'b0;                           // mode 0 idles low
        repeat (SCK_HALF) @(negedge clk);
        spi_cs = 1'b1;
        draw_gap(gap);
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        int pos;
        int txn;
        reset    = 1'b1;
        spi_cs   = 1'b1;
        spi_sck  = 1'b0;
        spi_copi = 1'b0;
        lfsr     = 16'd17347;
        errors   = 0;
        checked  = 0;
        load_stimulus();
        repeat (3) @(negedge clk);                // 3 cycles of reset
        reset = 1'b0;
        repeat (GAP_MIN) @(negedge clk);
        if (stimulus_ok) begin
            pos = 0;
            txn = 0;
            while (pos < tokens.size()) begin
                run_transaction(txn, pos);
                pos += 1 + 2 * tokens[pos];
                txn++;
            end
        end
        $display("%0d errors in %0d bytes checked over %0d transactions",
                 errors, checked, txn_count);
        if (stimulus_ok && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // cycle watchdog, armed once the file is sized
    initial begin
        cycles = 0;
        while (timeout_limit == 0 || cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the transactions did not finish.", cycles);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/spi_stimulus.txt
# one transaction: byte count, bytes sent on COPI, bytes expected on CIPO, all fields hex
# a long record continues on the next line, # starts a comment
# reset state, full read from address 0
12 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
   00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
# burst write at 3, then read back
06 83 11 22 33 44 A5  00 00 00 00 00 00
07 03 00 00 00 00 00 00  00 00 11 22 33 44 A5
# write at 14 wraps to 0 and 1, then read back in order
05 8E 5A C3 96 69  00 00 00 00 00
06 0E 00 00 00 00 00  00 00 5A C3 96 69
# header bits 6..4 ignored, single register reads
02 F2 7E  00 00
03 02 00 00  00 00 7E
03 06 00 00  00 00 44
# headers with no data bytes change nothing
01 85  00
01 4A  00
# full read confirms every register
12 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
   00 00 96 69 7E 11 22 33 44 A5 00 00 00 00 00 00 5A C3

//--- verilog/addr_counter.sv
// Transaction address counter
`default_nettype none

module addr_counter (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              load_i,       // header byte decoded
    input  logic [spi_bridge_pkg::ADDR_W-1:0] load_addr_i,  // start address from header
    input  logic                              step_addr_i,  // next register
    input  logic                              step_byte_i,  // byte boundary passed
    output logic [spi_bridge_pkg::ADDR_W-1:0] addr_o,
    output logic [1:0]                        byte_index_o  // 3 = past turnaround
);
    import spi_bridge_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_o       <= '0;
            byte_index_o <= 2'd0;
        end else if (load_i) begin
            addr_o       <= load_addr_i;
            byte_index_o <= 2'd1;                  // header done
        end else begin
            if (step_addr_i) begin
                addr_o <= addr_o + 1'b1;           // wraps mod 16
            end
            if (step_byte_i && byte_index_o != 2'd3) begin
                byte_index_o <= byte_index_o + 2'd1; // saturate
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_bank.sv
// Wishbone register bank
`default_nettype none

module reg_bank (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              wb_cyc_i,
    input  logic                              wb_stb_i,
    input  logic                              wb_we_i,
    input  logic [spi_bridge_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [spi_bridge_pkg::DATA_W-1:0] wb_dat_i,
    output logic                              wb_ack_o,   // one clock per access
    output logic [spi_bridge_pkg::DATA_W-1:0] wb_dat_o    // valid with ack
);
    import spi_bridge_pkg::*;

    logic [DATA_W-1:0] regs_q [REG_COUNT];
    logic              access;                 // new request this clock

    // ack low gates off the second clock of the same request
    assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            wb_ack_o <= access;
            if (access && wb_we_i) begin
                regs_q[wb_adr_i] <= wb_dat_i;  // stored on the ack edge
            end
        end
    end

    // read port, old value on writes is ignored by the master
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_o <= regs_q[wb_adr_i];
        end
    end

endmodule

`default_nettype wire

//--- verilog/spi_bridge_pkg.sv
// SPI register bridge constants
`default_nettype none

package spi_bridge_pkg;

    // byte and register sizes
    localparam int DATA_W    = 8;                   // SPI byte and register width
    localparam int ADDR_W    = 4;                   // register address width
    localparam int REG_COUNT = 16;                  // registers in the bank

    // header byte layout, bits 6..4 are don't care
    localparam int HDR_WRITE_BIT = 7;               // 1 = write burst, 0 = read burst

    // CIPO filler while no read data is due
    localparam logic [DATA_W-1:0] IDLE_TX_BYTE = 8'h00;

endpackage

`default_nettype wire

//--- verilog/spi_reg_bridge.sv
// SPI to register bridge top
`default_nettype none

module spi_reg_bridge (
    input  logic clk,
    input  logic reset_i,
    input  logic spi_sck_i,   // mode 0 clock
    input  logic spi_copi_i,
    input  logic spi_cs_i,    // active low
    output logic spi_cipo_o
);
    import spi_bridge_pkg::*;

    // byte layer to sequencer
    logic              cs_active;
    logic              receive_strobe;
    logic [DATA_W-1:0] receive_byte;
    logic              transmit_strobe;
    logic [DATA_W-1:0] transmit_byte;

    // sequencer to counter
    logic              load;
    logic [ADDR_W-1:0] load_addr;
    logic              step_addr;
    logic              step_byte;
    logic [ADDR_W-1:0] addr;
    logic [1:0]        byte_index;

    // internal wishbone
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;

    spi_target u_target (
        .clk(clk), .reset_i(reset_i),
        .spi_sck_i(spi_sck_i), .spi_copi_i(spi_copi_i), .spi_cipo_o(spi_cipo_o),
        .spi_cs_i(spi_cs_i), .cs_active_o(cs_active),
        .receive_strobe_o(receive_strobe), .receive_byte_o(receive_byte),
        .transmit_strobe_o(transmit_strobe), .transmit_byte_i(transmit_byte)
    );

    xfer_fsm u_fsm (
        .clk(clk), .reset_i(reset_i), .cs_active_i(cs_active),
        .receive_strobe_i(receive_strobe), .receive_byte_i(receive_byte),
        .transmit_strobe_i(transmit_strobe), .transmit_byte_o(transmit_byte),
        .load_o(load), .load_addr_o(load_addr), .step_addr_o(step_addr),
        .step_byte_o(step_byte), .addr_i(addr), .byte_index_i(byte_index),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack)
    );

    addr_counter u_addr (
        .clk(clk), .reset_i(reset_i), .load_i(load), .load_addr_i(load_addr),
        .step_addr_i(step_addr), .step_byte_i(step_byte),
        .addr_o(addr), .byte_index_o(byte_index)
    );

    reg_bank u_regs (
        .clk(clk), .reset_i(reset_i), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
        .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r)
    );

endmodule

`default_nettype wire

//--- verilog/spi_target.sv
// SPI mode 0 byte shifter
`default_nettype none

module spi_target (
    input  logic                              clk,               // system clock, ~4x SCK
    input  logic                              reset_i,           // sync reset
    input  logic                              spi_sck_i,         // SPI clock pin
    input  logic                              spi_copi_i,        // data from initiator
    output logic                              spi_cipo_o,        // data to initiator
    input  logic                              spi_cs_i,          // chip select, active low
    output logic                              cs_active_o,       // synchronized select level
    output logic                              receive_strobe_o,  // one clock per received byte
    output logic [spi_bridge_pkg::DATA_W-1:0] receive_byte_o,    // last byte from initiator
    output logic                              transmit_strobe_o, // transmit_byte_i was taken
    input  logic [spi_bridge_pkg::DATA_W-1:0] transmit_byte_i    // next byte to shift out
);
    import spi_bridge_pkg::*;

    logic [1:0]                cs_sync;   // [0] is the settled level
    logic [1:0]                copi_sync; // [0] is the settled level
    logic [2:0]                sck_sync;  // [1] settled, [0] previous for edge detect
    logic                      sck_rise;
    logic                      sck_fall;
    logic                      cs_n;      // synchronized CS, still active low
    logic [DATA_W-1:0]         shift_q;   // shared in/out shifter
    logic [DATA_W-1:0]         shift_in;  // shifter with next COPI bit appended
    logic [$clog2(DATA_W)-1:0] bit_cnt;   // bit position inside the byte

    assign sck_rise    = sck_sync[1] & ~sck_sync[0];
    assign sck_fall    = ~sck_sync[1] & sck_sync[0];
    assign cs_n        = cs_sync[0];
    assign cs_active_o = ~cs_n;
    assign shift_in    = {shift_q[DATA_W-2:0], copi_sync[0]};
    assign spi_cipo_o  = shift_q[DATA_W-1];       // msb first

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_sync           <= 2'b11;           // deselected
            copi_sync         <= 2'b00;
            sck_sync          <= 3'b000;
            shift_q           <= '0;
            bit_cnt           <= '0;
            receive_strobe_o  <= 1'b0;
            transmit_strobe_o <= 1'b0;
        end else begin
            // pins enter at the top and shift down
            cs_sync   <= {spi_cs_i, cs_sync[1]};
            copi_sync <= {spi_copi_i, copi_sync[1]};
            sck_sync  <= {spi_sck_i, sck_sync[2:1]};

            receive_strobe_o  <= 1'b0;
            transmit_strobe_o <= 1'b0;

            if (cs_n) begin                       // idle, keep reloading
                shift_q           <= transmit_byte_i;
                transmit_strobe_o <= 1'b1;
                bit_cnt           <= '0;
            end else if (sck_rise) begin          // mode 0 samples on rise
                shift_q          <= shift_in;
                receive_strobe_o <= &bit_cnt;     // 8th bit done
            end else if (sck_fall) begin
                bit_cnt <= bit_cnt + 1'b1;        // wraps at byte end
                if (&bit_cnt) begin               // byte boundary
                    shift_q           <= transmit_byte_i;
                    transmit_strobe_o <= 1'b1;
                end
            end
        end
    end

    // received byte, only updated at the 8th rise
    always_ff @(posedge clk) begin
        if (!cs_n && sck_rise && (&bit_cnt)) begin
            receive_byte_o <= shift_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/xfer_fsm.sv
// SPI transaction sequencer
`default_nettype none

module xfer_fsm (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              cs_active_i,      // synchronized select
    input  logic                              receive_strobe_i, // byte received
    input  logic [spi_bridge_pkg::DATA_W-1:0] receive_byte_i,
    input  logic                              transmit_strobe_i, // transmit byte consumed
    output logic [spi_bridge_pkg::DATA_W-1:0] transmit_byte_o,
    output logic                              load_o,           // header seen
    output logic [spi_bridge_pkg::ADDR_W-1:0] load_addr_o,      // start address
    output logic                              step_addr_o,
    output logic                              step_byte_o,
    input  logic [spi_bridge_pkg::ADDR_W-1:0] addr_i,           // current register
    input  logic [1:0]                        byte_index_i,     // 1 = turnaround pending
    output logic                              wb_cyc_o,
    output logic                              wb_stb_o,
    output logic                              wb_we_o,
    output logic [spi_bridge_pkg::ADDR_W-1:0] wb_adr_o,
    output logic [spi_bridge_pkg::DATA_W-1:0] wb_dat_o,
    input  logic [spi_bridge_pkg::DATA_W-1:0] wb_dat_i,
    input  logic                              wb_ack_i
);
    import spi_bridge_pkg::*;

    typedef enum logic [2:0] {
        IDLE, HEADER, WRITE_DATA, READ_WAIT, READ_STREAM, BUS
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic              rd_mode_q;  // read transaction in progress
    logic              we_q;       // direction of current bus cycle
    logic              start_wr;   // write byte arrived
    logic [DATA_W-1:0] wdata_q;    // byte being written
    logic [DATA_W-1:0] hold_q;     // next byte for CIPO

    assign load_addr_o = receive_byte_i[ADDR_W-1:0];   // bits 6..4 dropped
    assign wb_cyc_o    = (state_q == BUS);             // cyc and stb move together
    assign wb_stb_o    = (state_q == BUS);
    assign wb_we_o     = we_q;
    assign wb_adr_o    = addr_i;                       // counter holds still during BUS
    assign wb_dat_o    = wdata_q;
    assign step_byte_o = cs_active_i & transmit_strobe_i;

    // hold reg goes out once the turnaround byte is under way
    assign transmit_byte_o = (rd_mode_q && byte_index_i != 2'd1) ? hold_q : IDLE_TX_BYTE;

    always_comb begin
        state_d     = state_q;
        load_o      = 1'b0;
        step_addr_o = 1'b0;
        start_wr    = 1'b0;
        case (state_q)
            IDLE: begin
                if (cs_active_i) state_d = HEADER;
            end
            HEADER: begin
                if (!cs_active_i) begin
                    state_d = IDLE;
                end else if (receive_strobe_i) begin
                    load_o  = 1'b1;
                    state_d = receive_byte_i[HDR_WRITE_BIT] ? WRITE_DATA : BUS; // read fetches
                end
            end
            WRITE_DATA: begin
                if (!cs_active_i) begin
                    state_d = IDLE;
                end else if (receive_strobe_i) begin
                    start_wr = 1'b1;
                    state_d  = BUS;
                end
            end
            READ_WAIT: begin                           // wait out turnaround byte
                if (!cs_active_i) state_d = IDLE;
                else if (byte_index_i != 2'd1) state_d = READ_STREAM;
            end
            READ_STREAM: begin
                if (!cs_active_i) begin
                    state_d = IDLE;
                end else if (transmit_strobe_i) begin  // hold_q taken, fetch next
                    step_addr_o = 1'b1;
                    state_d     = BUS;
                end
            end
            BUS: begin
                if (wb_ack_i) begin
                    step_addr_o = we_q;                // writes advance after the store
                    if (!cs_active_i) state_d = IDLE;
                    else if (we_q) state_d = WRITE_DATA;
                    else if (byte_index_i == 2'd1) state_d = READ_WAIT;
                    else state_d = READ_STREAM;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= IDLE;
            rd_mode_q <= 1'b0;
            we_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) rd_mode_q <= 1'b0;
            else if (load_o) rd_mode_q <= ~receive_byte_i[HDR_WRITE_BIT];
            if (state_q != BUS) we_q <= start_wr;      // frozen for the whole access
        end
    end

    always_ff @(posedge clk) begin
        if (start_wr) wdata_q <= receive_byte_i;
        if (state_q == BUS && wb_ack_i && !we_q) hold_q <= wb_dat_i;  // read data with ack
    end

endmodule

`default_nettype wire
